// ==== common/kc_io_pkg.sv ====
// Board I/O shared definitions
`default_nettype none

package kc_io_pkg;

  // ================================================
  // Timing
  // ================================================

  // Simulation speed-up divider for the serial line
  localparam int CLKS_PER_BIT = 16;
  localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);

  // Cycles a switch value must stay stable
  localparam int DEB_CYCLES = 8;
  localparam int DEB_CNT_W = $clog2(DEB_CYCLES + 1);

  // ================================================
  // Command encoding
  // ================================================

  // Upper nibble of a command byte
  typedef enum logic [3:0] {
    OP_LED_LO   = 4'h1,
    OP_LED_HI   = 4'h2,
    OP_READ_DIP = 4'h3,
    OP_PING     = 4'h4
  } opcode_e;

  // Fixed replies
  localparam logic [7:0] REPLY_BAD_OP = 8'hEE;
  localparam logic [7:0] REPLY_FRAME_ERR = 8'hFE;

  // Unsolicited switch report with the switches in the low nibble
  localparam logic [3:0] EVT_NIBBLE = 4'hA;

  // ================================================
  // Serial FSM
  // ================================================

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_e;

endpackage

`default_nettype wire

// ==== common/uart_link_if.sv ====
// UART byte link
`timescale 1ns/1ps
`default_nettype none

interface uart_link_if;

  // Receive side
  logic [7:0] rx_data;
  logic       rx_valid;
  logic       rx_frame_err;

  // Transmit side
  logic [7:0] tx_data;
  logic       tx_send;
  logic       tx_busy;

  modport rx_mp (
    output rx_data,
    output rx_valid,
    output rx_frame_err
  );

  modport tx_mp (
    input  tx_data,
    input  tx_send,
    output tx_busy
  );

  modport ctrl_mp (
    input  rx_data,
    input  rx_valid,
    input  rx_frame_err,
    output tx_data,
    output tx_send,
    input  tx_busy
  );

endinterface

`default_nettype wire

// ==== uart/uart_rx.sv ====
// UART 8N1 receiver
`timescale 1ns/1ps
`default_nettype none

module uart_rx import kc_io_pkg::*; (
  input  wire        clk,
  input  wire        i_rst,
  input  wire        i_rd,
  uart_link_if.rx_mp link
);

  logic [1:0]           rd_sync;
  uart_state_e          state;
  logic [CLK_CNT_W-1:0] clk_cnt;
  logic [2:0]           bit_idx;
  logic [7:0]           shreg;
  logic                 valid_q;
  logic                 frame_err_q;
  logic                 bit_end;
  logic                 half_bit;

  assign bit_end = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));
  assign half_bit = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1));

  // Line synchronizer that idles high
  always_ff @(posedge clk) begin
    if (i_rst) begin
      rd_sync <= 2'b11;
    end else begin
      rd_sync <= {rd_sync[0], i_rd};
    end
  end

  // ================================================
  // Frame FSM
  // ================================================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state       <= IDLE;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      valid_q     <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        IDLE: begin
          clk_cnt <= '0;
          if (!rd_sync[1]) begin
            state <= START;
          end
        end
        START: begin
          if (half_bit) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // Glitch shorter than half a bit
            state <= rd_sync[1] ? IDLE : DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        STOP: begin
          if (bit_end) begin
            valid_q     <= 1'b1;
            frame_err_q <= ~rd_sync[1];
            state       <= IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state == DATA && bit_end) begin
      shreg <= {rd_sync[1], shreg[7:1]};
    end
  end

  assign link.rx_data = shreg;
  assign link.rx_valid = valid_q;
  assign link.rx_frame_err = frame_err_q;

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
// UART 8N1 transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_tx import kc_io_pkg::*; (
  input  wire        clk,
  input  wire        i_rst,
  output logic       o_td,
  uart_link_if.tx_mp link
);

  uart_state_e          state;
  logic [CLK_CNT_W-1:0] clk_cnt;
  logic [2:0]           bit_idx;
  logic [7:0]           shreg;
  logic                 busy_q;
  logic                 bit_end;

  assign bit_end = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

  // ================================================
  // Frame FSM
  // ================================================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state   <= IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      busy_q  <= 1'b0;
      o_td    <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (link.tx_send) begin
            o_td   <= 1'b0;
            busy_q <= 1'b1;
            state  <= START;
          end
        end
        START, DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            // After the last data bit the shifted-in ones form the stop bit
            o_td <= shreg[0];
            if (state == START) begin
              state <= DATA;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              if (bit_idx == 3'd7) begin
                state <= STOP;
              end
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        STOP: begin
          if (bit_end) begin
            clk_cnt <= '0;
            busy_q  <= 1'b0;
            state   <= IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Shift out LSB first and fill with ones
  always_ff @(posedge clk) begin
    if (state == IDLE && link.tx_send) begin
      shreg <= link.tx_data;
    end else if ((state == START || state == DATA) && bit_end) begin
      shreg <= {1'b1, shreg[7:1]};
    end
  end

  assign link.tx_busy = busy_q;

endmodule

`default_nettype wire

// ==== rtl/dip_sampler.sv ====
// DIP switch debouncer
`timescale 1ns/1ps
`default_nettype none

module dip_sampler import kc_io_pkg::*; (
  input  wire        clk,
  input  wire        i_rst,
  input  wire  [3:0] i_dip,
  output logic [3:0] o_dip,
  output logic       o_dip_chg
);

  logic [3:0]           sync_1;
  logic [3:0]           sync_2;
  logic [3:0]           cand;
  logic [DEB_CNT_W-1:0] deb_cnt;

  // Two-stage synchronizer
  always_ff @(posedge clk) begin
    if (i_rst) begin
      sync_1 <= '0;
      sync_2 <= '0;
    end else begin
      sync_1 <= i_dip;
      sync_2 <= sync_1;
    end
  end

  // ================================================
  // Debounce
  // ================================================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      cand      <= '0;
      deb_cnt   <= '0;
      o_dip     <= '0;
      o_dip_chg <= 1'b0;
    end else begin
      o_dip_chg <= 1'b0;
      if (sync_2 != cand) begin
        // Bounce restarts the count
        cand    <= sync_2;
        deb_cnt <= '0;
      end else if (deb_cnt != DEB_CNT_W'(DEB_CYCLES)) begin
        deb_cnt <= deb_cnt + 1'b1;
        if (deb_cnt == DEB_CNT_W'(DEB_CYCLES - 1) && cand != o_dip) begin
          o_dip     <= cand;
          o_dip_chg <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cmd_ctrl.sv ====
// Command controller
`timescale 1ns/1ps
`default_nettype none

module cmd_ctrl import kc_io_pkg::*; (
  input  wire          clk,
  input  wire          i_rst,
  uart_link_if.ctrl_mp link,
  input  wire    [3:0] i_dip,
  input  wire          i_dip_chg,
  output logic   [7:0] o_led
);

  opcode_e    op;
  logic [3:0] arg;

  // Pending reply slot
  logic       rep_pend;
  logic [7:0] rep_byte;

  // Pending switch report slot
  logic       evt_pend;
  logic [7:0] evt_byte;

  logic       send_q;
  logic [7:0] send_byte;
  logic       tx_free;

  assign op = opcode_e'(link.rx_data[7:4]);
  assign arg = link.rx_data[3:0];

  // Busy rises one cycle late, so a send just issued blocks the next
  assign tx_free = !link.tx_busy && !send_q;

  // ================================================
  // Decode and LEDs
  // ================================================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_led <= '0;
    end else if (link.rx_valid && !link.rx_frame_err) begin
      case (op)
        OP_LED_LO: o_led[3:0] <= arg;
        OP_LED_HI: o_led[7:4] <= arg;
        default: ;
      endcase
    end
  end

  // ================================================
  // Pending slots and arbitration
  // ================================================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      rep_pend <= 1'b0;
      evt_pend <= 1'b0;
      send_q   <= 1'b0;
    end else begin
      send_q <= 1'b0;

      // Reply wins the transmitter
      if (tx_free && rep_pend) begin
        rep_pend <= 1'b0;
        send_q   <= 1'b1;
      end else if (tx_free && evt_pend) begin
        evt_pend <= 1'b0;
        send_q   <= 1'b1;
      end

      // New items override a clear in the same cycle
      if (link.rx_valid && (link.rx_frame_err || (op != OP_LED_LO && op != OP_LED_HI))) begin
        rep_pend <= 1'b1;
      end
      if (i_dip_chg) begin
        evt_pend <= 1'b1;
      end
    end
  end

  // Payload bytes
  always_ff @(posedge clk) begin
    if (link.rx_valid) begin
      if (link.rx_frame_err) begin
        rep_byte <= REPLY_FRAME_ERR;
      end else begin
        case (op)
          // LED commands keep any pending reply intact
          OP_LED_LO, OP_LED_HI: ;
          OP_READ_DIP: rep_byte <= {OP_READ_DIP, i_dip};
          OP_PING:     rep_byte <= link.rx_data;
          default:     rep_byte <= REPLY_BAD_OP;
        endcase
      end
    end
    if (i_dip_chg) begin
      evt_byte <= {EVT_NIBBLE, i_dip};
    end
    if (tx_free && rep_pend) begin
      send_byte <= rep_byte;
    end else if (tx_free && evt_pend) begin
      send_byte <= evt_byte;
    end
  end

  assign link.tx_send = send_q;
  assign link.tx_data = send_byte;

endmodule

`default_nettype wire

// ==== rtl/kc_io_top.sv ====
// Board I/O subsystem top
`timescale 1ns/1ps
`default_nettype none

module kc_io_top (
  input  wire        clk,
  input  wire        i_rst,
  input  wire        i_uart_rd,
  output logic       o_uart_td,
  input  wire  [3:0] i_dip,
  output logic [7:0] o_led
);

  // Debounced switches towards the controller
  logic [3:0] dip_db;
  logic       dip_chg;

  uart_link_if u_link ();

  // ================================================
  // Serial side
  // ================================================
  uart_rx u_uart_rx (
    .clk   (clk),
    .i_rst (i_rst),
    .i_rd  (i_uart_rd),
    .link  (u_link.rx_mp)
  );

  uart_tx u_uart_tx (
    .clk   (clk),
    .i_rst (i_rst),
    .o_td  (o_uart_td),
    .link  (u_link.tx_mp)
  );

  // ================================================
  // Switches and control
  // ================================================
  dip_sampler u_dip_sampler (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_dip     (i_dip),
    .o_dip     (dip_db),
    .o_dip_chg (dip_chg)
  );

  cmd_ctrl u_cmd_ctrl (
    .clk       (clk),
    .i_rst     (i_rst),
    .link      (u_link.ctrl_mp),
    .i_dip     (dip_db),
    .i_dip_chg (dip_chg),
    .o_led     (o_led)
  );

endmodule

`default_nettype wire

// ==== dv/kc_io_props.sv ====
// Board I/O bound checks
`timescale 1ns/1ps
`default_nettype none

module kc_io_props (
  input wire       clk,
  input wire       i_rst,
  input wire       i_uart_td,
  input wire [7:0] i_led,
  input wire       i_rx_valid,
  input wire       i_tx_send,
  input wire       i_tx_busy
);

  int err_count = 0;

  // Line idles high outside a frame
  td_idle: assert property (@(posedge clk) disable iff (i_rst) !i_tx_busy |-> i_uart_td)
    else begin
      $error("o_uart_td low while no frame is in progress");
      err_count++;
    end

  send_free: assert property (@(posedge clk) disable iff (i_rst) i_tx_send |-> !i_tx_busy)
    else begin
      $error("tx_send raised while tx_busy is high");
      err_count++;
    end

  led_follow: assert property (@(posedge clk) disable iff (i_rst)
    $changed(i_led) |-> $past(i_rx_valid))
    else begin
      $error("o_led changed without a received byte");
      err_count++;
    end

endmodule

bind kc_io_top kc_io_props u_props (
  .clk        (clk),
  .i_rst      (i_rst),
  .i_uart_td  (o_uart_td),
  .i_led      (o_led),
  .i_rx_valid (u_link.rx_valid),
  .i_tx_send  (u_link.tx_send),
  .i_tx_busy  (u_link.tx_busy)
);

`default_nettype wire

// ==== dv/kc_io_tb.sv ====
// Board I/O subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module kc_io_tb import kc_io_pkg::*; ();

  localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
  // About 30 command and reply frame pairs plus debounce settling
  localparam int MAX_CYCLES = 2 * 30 * FRAME_CYCLES + 50 * DEB_CYCLES;

  logic       clk = 1'b0;
  logic       i_rst;
  logic       i_uart_rd;
  logic [3:0] i_dip;
  wire        o_uart_td;
  wire  [7:0] o_led;

  logic [15:0] lfsr_state = 16'd62143;
  logic [7:0]  exp_q[$];
  logic [7:0]  led_exp;
  logic [3:0]  dip_now;
  logic        frame_busy = 1'b0;
  int          cycle_cnt = 0;

  kc_io_top uut (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_uart_rd (i_uart_rd),
    .o_uart_td (o_uart_td),
    .i_dip     (i_dip),
    .o_led     (o_led)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [3:0] rand_bits(input int n);
    logic [3:0] v;
    int         i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[2:0], lfsr_state[0]};
      lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
    end
    return v;
  endfunction

  task automatic check_led;
    assert (o_led === led_exp)
      else abort_run($sformatf("Error: o_led 0x%h expected 0x%h", o_led, led_exp));
  endtask

  // Host side 8N1 frame that starts and ends on a falling edge
  task automatic send_frame(input logic [7:0] b, input logic bad_stop);
    logic [9:0] bits;
    int         i;
    bits = {~bad_stop, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      i_uart_rd = bits[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    i_uart_rd = 1'b1;
    repeat (CLKS_PER_BIT) @(negedge clk);
  endtask

  // Quiet time afterwards catches a stray extra frame
  task automatic wait_drain;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (FRAME_CYCLES) @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  always @(negedge clk) begin
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run("Timeout: the run did not finish in time");
    end else if (uut.u_props.err_count != 0) begin
      abort_run("A bound property check failed");
    end
  end

  // ================================================
  // Serial monitor on o_uart_td
  // ================================================
  initial begin : frame_monitor
    logic [7:0] got;
    logic [7:0] want;
    int         i;
    wait (i_rst === 1'b0);
    forever begin
      @(negedge clk);
      if (o_uart_td === 1'b0) begin
        frame_busy = 1'b1;
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        assert (o_uart_td === 1'b0) else abort_run("Start bit on o_uart_td was too short");
        for (i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          got[i] = o_uart_td;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (o_uart_td === 1'b1) else abort_run("Stop bit on o_uart_td was low");
        assert (exp_q.size() > 0)
          else abort_run($sformatf("Unexpected frame 0x%h on o_uart_td", got));
        want = exp_q.pop_front();
        assert (got === want)
          else abort_run($sformatf("Error: o_uart_td 0x%h expected 0x%h", got, want));
        frame_busy = 1'b0;
      end
    end
  end

  // ================================================
  // Stimulus
  // ================================================
  initial begin
    logic [3:0] arg;
    logic [3:0] op;
    logic [3:0] glitch;
    int         i;
    i_rst = 1'b1;
    i_uart_rd = 1'b1;
    i_dip = 4'h0;
    led_exp = 8'h00;
    dip_now = 4'h0;
    repeat (2) @(negedge clk);
    i_rst = 1'b0;

    // Line stays idle until the first switch report
    for (i = 0; i < 4 * DEB_CYCLES; i++) begin
      @(negedge clk);
      assert (o_uart_td === 1'b1) else abort_run("o_uart_td left idle before any report");
    end
    check_led();
    dip_now = rand_bits(4);
    if (dip_now == 4'h0) begin
      dip_now = 4'h5;
    end
    exp_q.push_back({EVT_NIBBLE, dip_now});
    i_dip = dip_now;
    wait_drain();

    // LED nibbles take no reply
    for (i = 0; i < 4; i++) begin
      arg = rand_bits(4);
      if (i % 2 == 0) begin
        send_frame({OP_LED_LO, arg}, 1'b0);
        led_exp[3:0] = arg;
      end else begin
        send_frame({OP_LED_HI, arg}, 1'b0);
        led_exp[7:4] = arg;
      end
      check_led();
    end

    arg = rand_bits(4);
    exp_q.push_back({4'h3, dip_now});
    send_frame({OP_READ_DIP, arg}, 1'b0);
    wait_drain();
    arg = rand_bits(4);
    exp_q.push_back({4'h4, arg});
    send_frame({OP_PING, arg}, 1'b0);
    wait_drain();

    // Undefined opcodes and then a low stop bit
    arg = rand_bits(4);
    op = (arg > 4'd4) ? arg : arg + 4'd8;
    exp_q.push_back(REPLY_BAD_OP);
    send_frame({4'h0, arg}, 1'b0);
    exp_q.push_back(REPLY_BAD_OP);
    send_frame({op, arg}, 1'b0);
    wait_drain();
    exp_q.push_back(REPLY_FRAME_ERR);
    send_frame({OP_LED_HI, ~led_exp[7:4]}, 1'b1);
    check_led();
    wait_drain();

    // Short glitches are filtered
    for (i = 0; i < 3; i++) begin
      glitch = rand_bits(4);
      i_dip = dip_now ^ ((glitch == 4'h0) ? 4'h8 : glitch);
      repeat (DEB_CYCLES - 3) @(negedge clk);
      i_dip = dip_now;
      repeat (2) @(negedge clk);
    end
    repeat (FRAME_CYCLES) @(negedge clk);
    glitch = rand_bits(4);
    dip_now = dip_now ^ ((glitch == 4'h0) ? 4'h6 : glitch);
    exp_q.push_back({EVT_NIBBLE, dip_now});
    i_dip = dip_now;
    wait_drain();

    // Switch change while the ping reply is on the wire
    arg = rand_bits(4);
    exp_q.push_back({4'h4, arg});
    glitch = rand_bits(4);
    dip_now = dip_now ^ ((glitch == 4'h0) ? 4'h3 : glitch);
    exp_q.push_back({EVT_NIBBLE, dip_now});
    send_frame({OP_PING, arg}, 1'b0);
    wait (frame_busy);
    @(negedge clk);
    i_dip = dip_now;
    wait_drain();
    check_led();

    if (uut.u_props.err_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      abort_run("A bound property check failed");
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
common/kc_io_pkg.sv
common/uart_link_if.sv
uart/uart_rx.sv
uart/uart_tx.sv
rtl/dip_sampler.sv
rtl/cmd_ctrl.sv
rtl/kc_io_top.sv
dv/kc_io_props.sv
dv/kc_io_tb.sv

// ==== Bender.yml ====
package:
  name: kc_io

sources:
  - files:
      - common/kc_io_pkg.sv
      - common/uart_link_if.sv
      - uart/uart_rx.sv
      - uart/uart_tx.sv
      - rtl/dip_sampler.sv
      - rtl/cmd_ctrl.sv
      - rtl/kc_io_top.sv
  - target: simulation
    files:
      - dv/kc_io_props.sv
      - dv/kc_io_tb.sv
